//--- hw/fsb_async_fifo.sv
// dual-clock FIFO, gray-coded pointers crossed by two-flop synchronizers
// full flag on the write side, valid flag on the read side
`default_nettype none

module fsb_async_fifo #(
   parameter int width_p = 32,
   parameter int els_p   = 4
) (
   input  logic               w_clk_i,
   input  logic               w_rst_i,
   input  logic               w_enq_i,
   input  logic [width_p-1:0] w_data_i,
   output logic               w_full_o,

   input  logic               r_clk_i,
   input  logic               r_rst_i,
   input  logic               r_deq_i,
   output logic [width_p-1:0] r_data_o,
   output logic               r_valid_o
);

   // els_p is a power of two, at least 2
   localparam int lg_els_lp = $clog2(els_p);
   // one extra bit tells a full ring from an empty one
   localparam int ptr_w_lp  = lg_els_lp + 1;
   // top two gray bits flip after exactly els_p writes
   localparam logic [ptr_w_lp-1:0] wrap_mask_lp = ptr_w_lp'(3) << (ptr_w_lp - 2);

   // storage, written on w_clk_i only
   logic [width_p-1:0] mem_r [els_p];

   // write domain pointers
   logic [ptr_w_lp-1:0] w_bin_r;
   logic [ptr_w_lp-1:0] w_bin_n;
   logic [ptr_w_lp-1:0] w_gray_r;
   logic [ptr_w_lp-1:0] w_gray_n;
   // read pointer as seen from the write side
   logic [ptr_w_lp-1:0] r_gray_wsync;

   // read domain pointers
   logic [ptr_w_lp-1:0] r_bin_r;
   logic [ptr_w_lp-1:0] r_bin_n;
   logic [ptr_w_lp-1:0] r_gray_r;
   logic [ptr_w_lp-1:0] r_gray_n;
   // write pointer as seen from the read side
   logic [ptr_w_lp-1:0] w_gray_rsync;

   ////////////////////////////////////////
   // write side

   assign w_bin_n  = w_bin_r + ptr_w_lp'(w_enq_i);
   assign w_gray_n = w_bin_n ^ (w_bin_n >> 1);

   always_ff @(posedge w_clk_i) begin
      if (w_rst_i) begin
         w_bin_r  <= '0;
         w_gray_r <= '0;
      end else begin
         w_bin_r  <= w_bin_n;
         w_gray_r <= w_gray_n;
      end
   end

   always_ff @(posedge w_clk_i) begin
      if (w_enq_i) begin
         mem_r[w_bin_r[lg_els_lp-1:0]] <= w_data_i;
      end
   end

   // registered gray pointer crosses, so only one bit moves per step
   fsb_sync_sync #(.width_p(ptr_w_lp)) r2w_ptr_sync (
      .oclk_i (w_clk_i),
      .rst_i  (w_rst_i),
      .data_i (r_gray_r),
      .data_o (r_gray_wsync)
   );

   // stale read pointer can only hold full longer
   assign w_full_o = (w_gray_r == (r_gray_wsync ^ wrap_mask_lp));

   ////////////////////////////////////////
   // read side

   assign r_bin_n  = r_bin_r + ptr_w_lp'(r_deq_i);
   assign r_gray_n = r_bin_n ^ (r_bin_n >> 1);

   always_ff @(posedge r_clk_i) begin
      if (r_rst_i) begin
         r_bin_r  <= '0;
         r_gray_r <= '0;
      end else begin
         r_bin_r  <= r_bin_n;
         r_gray_r <= r_gray_n;
      end
   end

   fsb_sync_sync #(.width_p(ptr_w_lp)) w2r_ptr_sync (
      .oclk_i (r_clk_i),
      .rst_i  (r_rst_i),
      .data_i (w_gray_r),
      .data_o (w_gray_rsync)
   );

   // head entry is stable once its pointer has crossed
   assign r_valid_o = (r_gray_r != w_gray_rsync);
   assign r_data_o  = mem_r[r_bin_r[lg_els_lp-1:0]];

   ////////////////////////////////////////
   // protocol checks from both neighbours

   // writer must watch full
   a_no_enq_full : assert property (
      @(posedge w_clk_i) disable iff (w_rst_i) !(w_enq_i && w_full_o)
   );

   // reader must watch valid
   a_no_deq_empty : assert property (
      @(posedge r_clk_i) disable iff (r_rst_i) !(r_deq_i && !r_valid_o)
   );

endmodule

`default_nettype wire

//--- hw/fsb_echo_node.sv
// echo node in the left domain
// echoes its own data packets, counts them, serves read and clear
`default_nettype none

module fsb_echo_node #(
   parameter logic [fsb_pkg::fsb_id_width_lp-1:0] node_id_p = 4'h5
) (
   input  logic              l_clk_i,
   input  logic              rst_i,
   input  logic              en_i,
   input  logic              in_v_i,
   input  fsb_pkg::fsb_pkt_u in_data_i,
   output logic              in_ready_o,
   output logic              out_v_o,
   output fsb_pkg::fsb_pkt_u out_data_o,
   input  logic              out_yumi_i
);

   logic                                  accept;
   logic                                  reply_gen;
   logic                                  count_inc;
   logic                                  count_clr;
   fsb_pkg::fsb_pkt_u                     reply_n;
   logic                                  out_v_r;
   fsb_pkg::fsb_pkt_u                     out_data_r;
   logic [fsb_pkg::fsb_count_width_lp-1:0] count_r;

   // room if empty or draining this cycle
   assign in_ready_o = en_i & (~out_v_r | out_yumi_i);
   assign accept     = in_v_i & in_ready_o;

   ////////////////////////////////////////
   // decode

   always_comb begin
      reply_n   = '0;
      reply_gen = 1'b0;
      count_inc = 1'b0;
      count_clr = 1'b0;
      // other ids fall through and are dropped
      if (in_data_i.data.dest_id == node_id_p) begin
         if (!in_data_i.data.cmd) begin
            count_inc               = 1'b1;
            reply_gen               = 1'b1;
            reply_n.data.dest_id    = fsb_pkg::fsb_host_id_lp;
            reply_n.data.cmd        = 1'b0;
            reply_n.data.payload    = in_data_i.data.payload;
         end else begin
            case (in_data_i.ctrl.opcode)
               fsb_pkg::op_read_count: begin
                  reply_gen            = 1'b1;
                  reply_n.ctrl.dest_id = fsb_pkg::fsb_host_id_lp;
                  reply_n.ctrl.cmd     = 1'b1;
                  reply_n.ctrl.opcode  = fsb_pkg::op_read_count;
                  reply_n.ctrl.arg     = count_r;
               end
               // clear sends no reply
               fsb_pkg::op_clear_count: count_clr = 1'b1;
               default: ;
            endcase
         end
      end
   end

   ////////////////////////////////////////
   // state

   // wraps at 23 bits
   always_ff @(posedge l_clk_i) begin
      if (rst_i) begin
         count_r <= '0;
      end else if (accept && count_clr) begin
         count_r <= '0;
      end else if (accept && count_inc) begin
         count_r <= count_r + 1'b1;
      end
   end

   // output register takes a new reply even on the yumi edge
   always_ff @(posedge l_clk_i) begin
      if (rst_i) begin
         out_v_r <= 1'b0;
      end else if (accept && reply_gen) begin
         out_v_r <= 1'b1;
      end else if (out_yumi_i) begin
         out_v_r <= 1'b0;
      end
   end

   always_ff @(posedge l_clk_i) begin
      if (accept && reply_gen) begin
         out_data_r <= reply_n;
      end
   end

   assign out_v_o    = out_v_r;
   assign out_data_o = out_data_r;

   // buffer takes a reply only while one is held
   a_yumi_with_v : assert property (
      @(posedge l_clk_i) disable iff (rst_i)
      out_yumi_i |-> out_v_o
   );

endmodule

`default_nettype wire

//--- hw/fsb_node_async_buffer.sv
// ring <-> node clock crossing
// two async FIFOs and the enable synchronizer
`default_nettype none

module fsb_node_async_buffer #(
   parameter int fifo_els_p = 4
) (
   // node side, left
   input  logic              l_clk_i,
   input  logic              l_rst_i,
   output logic              l_en_o,
   output logic              l_v_o,
   output fsb_pkg::fsb_pkt_u l_data_o,
   input  logic              l_ready_i,
   input  logic              l_v_i,
   input  fsb_pkg::fsb_pkt_u l_data_i,
   // late, follows l_v_i in the same cycle
   output logic              l_yumi_o,

   // ring side, right
   input  logic              r_clk_i,
   input  logic              r_rst_i,
   input  logic              r_en_i,
   input  logic              r_v_i,
   input  fsb_pkg::fsb_pkt_u r_data_i,
   output logic              r_ready_o,
   output logic              r_v_o,
   output fsb_pkg::fsb_pkt_u r_data_o,
   input  logic              r_yumi_i
);

   // ring side write full
   logic r_full;
   // node side write full
   logic l_full;

   ////////////////////////////////////////
   // ring to node

   assign r_ready_o = ~r_full;

   fsb_async_fifo #(
      .width_p (fsb_pkg::fsb_pkt_width_lp),
      .els_p   (fifo_els_p)
   ) r2l_fifo (
      .w_clk_i   (r_clk_i),
      .w_rst_i   (r_rst_i),
      .w_enq_i   (r_v_i & ~r_full),
      .w_data_i  (r_data_i),
      .w_full_o  (r_full),
      .r_clk_i   (l_clk_i),
      .r_rst_i   (l_rst_i),
      .r_deq_i   (l_v_o & l_ready_i),
      .r_data_o  (l_data_o),
      .r_valid_o (l_v_o)
   );

   ////////////////////////////////////////
   // node to ring

   // take the reply whenever there is room
   assign l_yumi_o = l_v_i & ~l_full;

   fsb_async_fifo #(
      .width_p (fsb_pkg::fsb_pkt_width_lp),
      .els_p   (fifo_els_p)
   ) l2r_fifo (
      .w_clk_i   (l_clk_i),
      .w_rst_i   (l_rst_i),
      .w_enq_i   (l_yumi_o),
      .w_data_i  (l_data_i),
      .w_full_o  (l_full),
      .r_clk_i   (r_clk_i),
      .r_rst_i   (r_rst_i),
      .r_deq_i   (r_yumi_i),
      .r_data_o  (r_data_o),
      .r_valid_o (r_v_o)
   );

   // level enable, a few cycles of skew is harmless
   fsb_sync_sync #(.width_p(1)) en_sync (
      .oclk_i (l_clk_i),
      .rst_i  (l_rst_i),
      .data_i (r_en_i),
      .data_o (l_en_o)
   );

endmodule

`default_nettype wire

//--- hw/fsb_pkg.sv
// ring packet layout shared by the bridge and the echo node
// union views, field widths, opcodes, host id
`default_nettype none

package fsb_pkg;

   // field widths
   localparam int fsb_id_width_lp      = 4;
   localparam int fsb_payload_width_lp = 27;
   localparam int fsb_opcode_width_lp  = 4;
   localparam int fsb_count_width_lp   = 23;
   localparam int fsb_pkt_width_lp     = fsb_id_width_lp + 1 + fsb_payload_width_lp;

   // every reply goes back to this id
   localparam logic [fsb_id_width_lp-1:0] fsb_host_id_lp = 4'h0;

   // control opcodes, anything else is dropped by the node
   typedef enum logic [fsb_opcode_width_lp-1:0] {
      op_read_count  = 4'h1,
      op_clear_count = 4'h2
   } fsb_opcode_e;

   // one ring word, cmd picks the view
   typedef union packed {
      // cmd = 0
      struct packed {
         logic [fsb_id_width_lp-1:0]      dest_id;
         logic                            cmd;
         logic [fsb_payload_width_lp-1:0] payload;
      } data;
      // cmd = 1
      struct packed {
         logic [fsb_id_width_lp-1:0]     dest_id;
         logic                           cmd;
         logic [fsb_opcode_width_lp-1:0] opcode;
         logic [fsb_count_width_lp-1:0]  arg;
      } ctrl;
   } fsb_pkt_u;

endpackage

`default_nettype wire

//--- hw/fsb_subsystem_top.sv
// ring bridge top, reset synchronizers plus buffer and echo node
`default_nettype none

module fsb_subsystem_top #(
   parameter int                                 fifo_els_p = 4,
   parameter logic [fsb_pkg::fsb_id_width_lp-1:0] node_id_p  = 4'h5
) (
   input  logic              l_clk_i,
   input  logic              r_clk_i,
   input  logic              rst_i,
   input  logic              r_en_i,
   input  logic              r_v_i,
   input  fsb_pkg::fsb_pkt_u r_data_i,
   output logic              r_ready_o,
   output logic              r_v_o,
   output fsb_pkg::fsb_pkt_u r_data_o,
   input  logic              r_yumi_i
);

   // per-domain resets
   logic              r_rst;
   logic              l_rst;
   // node side links
   logic              l_en;
   logic              l_v;
   fsb_pkg::fsb_pkt_u l_data;
   logic              l_ready;
   logic              reply_v;
   fsb_pkg::fsb_pkt_u reply_data;
   logic              l_yumi;

   ////////////////////////////////////////
   // reset into each clock domain

   fsb_sync_sync #(.width_p(1)) r_rst_sync (
      .oclk_i (r_clk_i),
      .rst_i  (1'b0),
      .data_i (rst_i),
      .data_o (r_rst)
   );

   fsb_sync_sync #(.width_p(1)) l_rst_sync (
      .oclk_i (l_clk_i),
      .rst_i  (1'b0),
      .data_i (rst_i),
      .data_o (l_rst)
   );

   ////////////////////////////////////////
   // crossing and node

   fsb_node_async_buffer #(.fifo_els_p(fifo_els_p)) buf0 (
      .l_clk_i   (l_clk_i),
      .l_rst_i   (l_rst),
      .l_en_o    (l_en),
      .l_v_o     (l_v),
      .l_data_o  (l_data),
      .l_ready_i (l_ready),
      .l_v_i     (reply_v),
      .l_data_i  (reply_data),
      .l_yumi_o  (l_yumi),
      .r_clk_i   (r_clk_i),
      .r_rst_i   (r_rst),
      .r_en_i    (r_en_i),
      .r_v_i     (r_v_i),
      .r_data_i  (r_data_i),
      .r_ready_o (r_ready_o),
      .r_v_o     (r_v_o),
      .r_data_o  (r_data_o),
      .r_yumi_i  (r_yumi_i)
   );

   fsb_echo_node #(.node_id_p(node_id_p)) node0 (
      .l_clk_i    (l_clk_i),
      .rst_i      (l_rst),
      .en_i       (l_en),
      .in_v_i     (l_v),
      .in_data_i  (l_data),
      .in_ready_o (l_ready),
      .out_v_o    (reply_v),
      .out_data_o (reply_data),
      .out_yumi_i (l_yumi)
   );

endmodule

`default_nettype wire

//--- hw/fsb_sync_sync.sv
// two-flop synchronizer into the output clock domain
`default_nettype none

module fsb_sync_sync #(
   parameter int width_p = 1
) (
   input  logic               oclk_i,
   input  logic               rst_i,
   input  logic [width_p-1:0] data_i,
   output logic [width_p-1:0] data_o
);

   // first stage may go metastable
   logic [width_p-1:0] meta_r;
   // second stage is safe to use
   logic [width_p-1:0] sync_r;

   // tie rst_i low when this carries a reset itself
   always_ff @(posedge oclk_i) begin
      if (rst_i) begin
         meta_r <= '0;
         sync_r <= '0;
      end else begin
         meta_r <= data_i;
         sync_r <= meta_r;
      end
   end

   // two oclk edges from data_i to data_o
   assign data_o = sync_r;

endmodule

`default_nettype wire

//--- project.f
hw/fsb_pkg.sv
hw/fsb_sync_sync.sv
hw/fsb_async_fifo.sv
hw/fsb_node_async_buffer.sv
hw/fsb_echo_node.sv
hw/fsb_subsystem_top.sv
tests/tb_fsb_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# build the ring bridge testbench with Verilator, run it, scan the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_fsb_subsystem \
   -f project.f -o tb_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -q "Simulation finished: FAIL" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "no pass line, see sim.log"; exit 1; }
echo "PASS"

//--- tests/tb_fsb_subsystem.sv
// testbench for the ring bridge, clocks, LFSR, reply model, checkers
// directed tests for echo, counting, clear, enable and back-pressure
`default_nettype none

module tb_fsb_subsystem;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int          fifo_els_lp = 4;
   localparam logic [3:0]  node_id_lp  = 4'h5;
   localparam logic [31:0] seed_lp     = 32'h41d8217d;
   localparam int          count_w_lp  = fsb_pkg::fsb_count_width_lp;
   localparam int          pay_w_lp    = fsb_pkg::fsb_payload_width_lp;
   // packets per test feed the watchdog time
   localparam int n_echo_lp  = 20;
   localparam int n_mix_lp   = 16;
   localparam int n_clear_lp = 6;
   localparam int n_gate_lp  = 2 * fifo_els_lp;
   localparam int n_bp_lp    = 30;
   localparam int n_total_lp = n_echo_lp + n_mix_lp + n_clear_lp + n_gate_lp + n_bp_lp;

   logic              r_clk = 1'b0;
   logic              l_clk = 1'b0;
   logic              rst;
   logic              r_en;
   logic              r_v_in;
   fsb_pkg::fsb_pkt_u r_data_in;
   logic              r_ready;
   logic              r_v_out;
   fsb_pkg::fsb_pkt_u r_data_out;
   logic              r_yumi = 1'b0;

   // expected replies in ring order
   fsb_pkg::fsb_pkt_u     exp_q[$];
   logic [count_w_lp-1:0] count_m;
   // separate streams for payloads and yumi
   logic [31:0]           pay_lfsr;
   logic [31:0]           yumi_lfsr;
   logic                  yumi_rand;

   // 4 ns ring clock, 7 ns node clock
   always #2 r_clk = ~r_clk;
   always #3.5 l_clk = ~l_clk;

   fsb_subsystem_top #(
      .fifo_els_p (fifo_els_lp),
      .node_id_p  (node_id_lp)
   ) dut0 (
      .l_clk_i   (l_clk),
      .r_clk_i   (r_clk),
      .rst_i     (rst),
      .r_en_i    (r_en),
      .r_v_i     (r_v_in),
      .r_data_i  (r_data_in),
      .r_ready_o (r_ready),
      .r_v_o     (r_v_out),
      .r_data_o  (r_data_out),
      .r_yumi_i  (r_yumi)
   );

   ////////////////////////////////////////
   // helpers

   // galois step with feedback mask 32'h80200003
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
   endfunction

   // one step per payload bit
   function automatic logic [pay_w_lp-1:0] next_payload();
      logic [pay_w_lp-1:0] p;
      p = '0;
      for (int i = 0; i < pay_w_lp; i++) begin
         p[i]     = pay_lfsr[0];
         pay_lfsr = lfsr_step(pay_lfsr);
      end
      return p;
   endfunction

   function automatic fsb_pkg::fsb_pkt_u make_data(input logic [3:0] dest);
      fsb_pkg::fsb_pkt_u p;
      p              = '0;
      p.data.dest_id = dest;
      p.data.payload = next_payload();
      return p;
   endfunction

   function automatic fsb_pkg::fsb_pkt_u make_ctrl(input logic [3:0] dest,
                                                   input logic [3:0] op);
      fsb_pkg::fsb_pkt_u p;
      p              = '0;
      p.ctrl.dest_id = dest;
      p.ctrl.cmd     = 1'b1;
      p.ctrl.opcode  = op;
      return p;
   endfunction

   // node rules with replies pushed in acceptance order
   function automatic void model_node(input fsb_pkg::fsb_pkt_u pkt);
      fsb_pkg::fsb_pkt_u rep;
      rep = '0;
      if (pkt.data.dest_id != node_id_lp) begin
         return;
      end
      if (!pkt.data.cmd) begin
         count_m          = count_m + count_w_lp'(1);
         rep.data.dest_id = fsb_pkg::fsb_host_id_lp;
         rep.data.payload = pkt.data.payload;
         exp_q.push_back(rep);
      end else if (pkt.ctrl.opcode == fsb_pkg::op_read_count) begin
         rep.ctrl.dest_id = fsb_pkg::fsb_host_id_lp;
         rep.ctrl.cmd     = 1'b1;
         rep.ctrl.opcode  = fsb_pkg::op_read_count;
         rep.ctrl.arg     = count_m;
         exp_q.push_back(rep);
      end else if (pkt.ctrl.opcode == fsb_pkg::op_clear_count) begin
         count_m = '0;
      end
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_pkt(input string name, input fsb_pkg::fsb_pkt_u got,
                            input fsb_pkg::fsb_pkt_u exp);
      if (got !== exp) begin
         fail_run($sformatf("Error: %s got %h expected %h at %0t", name, got, exp, $time));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         fail_run($sformatf("Error: %s got %h expected %h at %0t", name, got, exp, $time));
      end
   endtask

   // holds the packet until r_ready_o takes it
   task automatic send_pkt(input fsb_pkg::fsb_pkt_u pkt);
      model_node(pkt);
      @(negedge r_clk);
      r_v_in    = 1'b1;
      r_data_in = pkt;
      while (!r_ready) @(negedge r_clk);
      @(negedge r_clk);
      r_v_in = 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0) @(posedge r_clk);
      // time for a stray reply to show up
      repeat (40) @(posedge r_clk);
   endtask

   ////////////////////////////////////////
   // ring-side receiver

   always @(negedge r_clk) begin : rx_side
      logic take;
      take = yumi_rand ? yumi_lfsr[0] : 1'b1;
      if (yumi_rand) begin
         yumi_lfsr = lfsr_step(yumi_lfsr);
      end
      r_yumi = 1'b0;
      if (r_v_out === 1'b1 && take) begin
         if (exp_q.size() == 0) begin
            fail_run("a reply came out of the ring port with none expected");
         end else begin
            check_pkt("r_data_o", r_data_out, exp_q.pop_front());
            r_yumi = 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // directed tests

   task automatic test_reset_levels();
      // both reset synchronizers have cleared by now
      repeat (6) @(negedge r_clk);
      check_bit("r_v_o", r_v_out, 1'b0);
      check_bit("r_ready_o", r_ready, 1'b1);
   endtask

   task automatic test_echo();
      for (int i = 0; i < n_echo_lp; i++) begin
         send_pkt(make_data(node_id_lp));
      end
      wait_drain();
   endtask

   task automatic test_count_drop();
      send_pkt(make_ctrl(node_id_lp, fsb_pkg::op_clear_count));
      for (int i = 0; i < 12; i++) begin
         // every third one is for another node
         if (i % 3 == 2) begin
            send_pkt(make_data(4'h3));
         end else begin
            send_pkt(make_data(node_id_lp));
         end
      end
      // foreign read and unknown opcode are both dropped
      send_pkt(make_ctrl(4'h9, fsb_pkg::op_read_count));
      send_pkt(make_ctrl(node_id_lp, 4'hf));
      send_pkt(make_ctrl(node_id_lp, fsb_pkg::op_read_count));
      wait_drain();
   endtask

   task automatic test_clear();
      send_pkt(make_ctrl(node_id_lp, fsb_pkg::op_clear_count));
      send_pkt(make_ctrl(node_id_lp, fsb_pkg::op_read_count));
      for (int i = 0; i < 3; i++) begin
         send_pkt(make_data(node_id_lp));
      end
      send_pkt(make_ctrl(node_id_lp, fsb_pkg::op_read_count));
      wait_drain();
   endtask

   task automatic test_enable_gating();
      fsb_pkg::fsb_pkt_u pkt;
      int                sent;
      sent = 0;
      @(negedge r_clk);
      r_en = 1'b0;
      // enable crosses into the node domain
      repeat (10) @(negedge r_clk);
      while (r_ready) begin
         if (sent == n_gate_lp) begin
            fail_run("r_ready_o stayed high while the node was disabled");
         end
         pkt = make_data(node_id_lp);
         model_node(pkt);
         r_v_in    = 1'b1;
         r_data_in = pkt;
         sent++;
         @(negedge r_clk);
         check_bit("r_v_o", r_v_out, 1'b0);
      end
      r_v_in = 1'b0;
      repeat (20) begin
         @(negedge r_clk);
         check_bit("r_v_o", r_v_out, 1'b0);
      end
      r_en = 1'b1;
      wait_drain();
   endtask

   task automatic test_backpressure();
      @(posedge r_clk);
      yumi_rand = 1'b1;
      for (int i = 0; i < n_bp_lp; i++) begin
         send_pkt(make_data(node_id_lp));
      end
      wait_drain();
      @(posedge r_clk);
      yumi_rand = 1'b0;
   endtask

   ////////////////////////////////////////
   // main sequence and watchdog

   initial begin
      rst       = 1'b1;
      r_en      = 1'b1;
      r_v_in    = 1'b0;
      r_data_in = '0;
      yumi_rand = 1'b0;
      pay_lfsr  = seed_lp;
      yumi_lfsr = seed_lp;
      count_m   = '0;
      repeat (8) @(negedge r_clk);
      rst = 1'b0;
      test_reset_levels();
      test_echo();
      test_count_drop();
      test_clear();
      test_enable_gating();
      test_backpressure();
      $display("Simulation finished: PASS");
      $finish;
   end

   // 200 ns per packet sent over all tests
   initial begin
      #(n_total_lp * 200);
      fail_run("watchdog expired before the tests finished");
   end

endmodule

`default_nettype wire
